//--- system_cases.txt
# all fields hex: W addr data strb | R addr expected | T byte | X byte
# C byte hold_cycles | D divider
W 0000 11223344 f
W 0004 a5a5a5a5 f
W 0ffc deadbeef f
R 0000 11223344
W 0000 000000ee 1
R 0000 112233ee
W 1004 5a000000 8
R 0004 5aa5a5a5
W 0004 00cc0000 4
R 1004 5acca5a5
W 0ffc 12345678 6
R 7ffc de3456ef
T 55
X a3
C 3c 20
D 6
T c1
X 7e
D 9
T 80
X 01
C e7 05

//--- flist.f
sys_pkg.sv
iob_bus_if.sv
split.sv
int_mem.sv
iob_uart.sv
uart_tx.sv
uart_rx.sv
system.sv
tb_system.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_system
LOG       ?= sim.log
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_system.sv
`timescale 1ns/1ps

module tb_system;

   localparam longint CLK_PERIOD = 100;
   localparam longint CASE_BUS_CYCLES = 64;
   localparam sys_pkg::bus_addr_t ADDR_TXDATA = 16'h8000;
   localparam sys_pkg::bus_addr_t ADDR_RXDATA = 16'h8004;
   localparam sys_pkg::bus_addr_t ADDR_STATUS = 16'h8008;
   localparam sys_pkg::bus_addr_t ADDR_DIV    = 16'h800c;
   localparam sys_pkg::bus_data_t DIV_AFTER_RESET = 32'd16;

   logic               clk;
   logic               rst_n;
   logic               valid;
   sys_pkg::bus_addr_t address;
   sys_pkg::bus_data_t wdata;
   sys_pkg::bus_strb_t wstrb;
   sys_pkg::bus_data_t rdata;
   logic               ready;
   logic               uart_txd;
   logic               uart_rxd;
   logic               uart_rts;
   logic               uart_cts;

   logic [31:0]        lfsr;
   int                 div_model;
   sys_pkg::bus_data_t mem_model [2 ** sys_pkg::MEM_ADDR_W];
   logic [7:0]         op_q [$];
   logic [31:0]        f0_q [$];
   logic [31:0]        f1_q [$];
   logic [31:0]        f2_q [$];
   logic               watchdog_armed = 1'b0;
   longint             watchdog_ns;

   system dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .valid    (valid),
      .address  (address),
      .wdata    (wdata),
      .wstrb    (wstrb),
      .rdata    (rdata),
      .ready    (ready),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic compare_data(input string name, input sys_pkg::bus_data_t want,
                               input sys_pkg::bus_data_t got);
      if (got !== want) begin
         abort_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, want, got));
      end
   endtask

   task automatic compare_byte(input string name, input sys_pkg::uart_byte_t want,
                               input sys_pkg::uart_byte_t got);
      if (got !== want) begin
         abort_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, want, got));
      end
   endtask

   task automatic compare_bit(input string name, input logic want, input logic got);
      if (got !== want) begin
         abort_run($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, want, got));
      end
   endtask

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bits(input int nbits, output int val);
      val = 0;
      for (int i = 0; i < nbits; i++) begin
         val = (val << 1) | int'(lfsr[31]);
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // one request with ready expected two cycles after valid
   task automatic bus_access(input sys_pkg::bus_addr_t addr, input sys_pkg::bus_data_t data,
                             input sys_pkg::bus_strb_t strb, output sys_pkg::bus_data_t rd);
      int idle;
      take_bits(2, idle);
      repeat (idle) @(posedge clk);
      @(posedge clk);
      #1;
      valid   = 1'b1;
      address = addr;
      wdata   = data;
      wstrb   = strb;
      for (int n = 0; n < 3; n++) begin
         @(negedge clk);
         compare_bit("ready", logic'(n == 2), ready);
      end
      rd = rdata;
      @(posedge clk);
      #1;
      valid   = 1'b0;
      address = '0;
      wdata   = '0;
      wstrb   = '0;
      // no second ready for the same request
      @(negedge clk);
      compare_bit("ready", 1'b0, ready);
   endtask

   // mid-bit samples of txd from the start edge on
   task automatic sample_tx_line(input sys_pkg::uart_byte_t b);
      sys_pkg::uart_byte_t got;
      got = '0;
      @(negedge clk);
      repeat (div_model / 2) @(negedge clk);
      compare_bit("uart_txd start bit", 1'b0, uart_txd);
      for (int k = 0; k < 8; k++) begin
         repeat (div_model) @(negedge clk);
         got[k] = uart_txd;
      end
      compare_byte("uart_txd byte", b, got);
      repeat (div_model) @(negedge clk);
      compare_bit("uart_txd stop bit", 1'b1, uart_txd);
   endtask

   task automatic check_tx_frame(input sys_pkg::uart_byte_t b);
      sys_pkg::bus_data_t st;
      int polls;
      @(negedge uart_txd);
      fork
         sample_tx_line(b);
         begin
            bus_access(ADDR_STATUS, '0, '0, st);
            compare_bit("status.tx_busy", 1'b1, st[0]);
         end
      join
      st = 32'h1;
      polls = 0;
      while (st[0] !== 1'b0) begin
         if (polls > div_model + 8) begin
            abort_run("tx_busy never cleared after the stop bit");
         end
         bus_access(ADDR_STATUS, '0, '0, st);
         polls++;
      end
   endtask

   task automatic drive_rx_frame(input sys_pkg::uart_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int k = 0; k < 10; k++) begin
         @(posedge clk);
         #1;
         uart_rxd = frame[k];
         repeat (div_model - 1) @(posedge clk);
      end
   endtask

   task automatic check_rx_frame(input sys_pkg::uart_byte_t b);
      sys_pkg::bus_data_t st;
      sys_pkg::bus_data_t rd;
      int polls;
      drive_rx_frame(b);
      st = '0;
      polls = 0;
      while (st[1] !== 1'b1) begin
         if (polls > div_model + 8) begin
            abort_run("rx_valid never set after the frame on uart_rxd");
         end
         bus_access(ADDR_STATUS, '0, '0, st);
         polls++;
      end
      compare_bit("uart_rts", 1'b0, uart_rts);
      bus_access(ADDR_RXDATA, '0, '0, rd);
      compare_byte("rxdata", b, rd[7:0]);
      bus_access(ADDR_STATUS, '0, '0, st);
      compare_bit("status.rx_valid", 1'b0, st[1]);
      compare_bit("uart_rts", 1'b1, uart_rts);
   endtask

   task automatic run_case(input logic [7:0] op, input logic [31:0] f0,
                           input logic [31:0] f1, input logic [31:0] f2);
      sys_pkg::bus_data_t             rd;
      sys_pkg::bus_data_t             want;
      sys_pkg::bus_data_t             mask;
      logic [sys_pkg::MEM_ADDR_W-1:0] idx;
      idx = f0[sys_pkg::MEM_ADDR_W+1:2];
      case (op)
         "W": begin
            // byte lanes enabled by the strobe take the write data
            mask = '0;
            for (int b = 0; b < sys_pkg::STRB_W; b++) begin
               mask[8*b +: 8] = {8{f2[b]}};
            end
            want = (mem_model[idx] & ~mask) | (f1 & mask);
            bus_access(f0[15:0], f1, f2[3:0], rd);
            compare_data("rdata", want, rd);
            mem_model[idx] = want;
         end
         "R": begin
            if (mem_model[idx] !== f1) begin
               abort_run($sformatf("case file expects %h at %h but the model holds %h",
                                   f1, f0[15:0], mem_model[idx]));
            end
            bus_access(f0[15:0], '0, '0, rd);
            compare_data("rdata", f1, rd);
         end
         "T": begin
            bus_access(ADDR_TXDATA, {24'h0, f0[7:0]}, 4'h1, rd);
            check_tx_frame(f0[7:0]);
         end
         "X": begin
            check_rx_frame(f0[7:0]);
         end
         "C": begin
            @(posedge clk);
            #1;
            uart_cts = 1'b0;
            bus_access(ADDR_TXDATA, {24'h0, f0[7:0]}, 4'h1, rd);
            for (int k = 0; k < int'(f1); k++) begin
               @(negedge clk);
               compare_bit("uart_txd while cts low", 1'b1, uart_txd);
            end
            @(posedge clk);
            #1;
            uart_cts = 1'b1;
            check_tx_frame(f0[7:0]);
         end
         default: begin
            bus_access(ADDR_DIV, f0, 4'h3, rd);
            bus_access(ADDR_DIV, '0, '0, rd);
            compare_data("div", {16'h0, f0[15:0]}, rd);
            div_model = int'(f0[15:0]);
         end
      endcase
   endtask

   task automatic load_cases();
      int            fd;
      int            code;
      logic [7:0]    op;
      logic [31:0]   f0;
      logic [31:0]   f1;
      logic [31:0]   f2;
      logic [1023:0] line;
      longint        cycles;
      longint        div_run;
      fd = $fopen("system_cases.txt", "r");
      if (fd == 0) begin
         abort_run("could not open system_cases.txt");
      end
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
         f0 = '0;
         f1 = '0;
         f2 = '0;
         case (op)
            "#": begin
               void'($fgets(line, fd));
               code = 1;
            end
            "W": code = $fscanf(fd, "%h %h %h", f0, f1, f2) - 2;
            "R", "C": code = $fscanf(fd, "%h %h", f0, f1) - 1;
            "T", "X", "D": code = $fscanf(fd, "%h", f0);
            default: code = 0;
         endcase
         if (code != 1) begin
            abort_run($sformatf("malformed line in system_cases.txt at op '%c'", op));
         end
         if (op != "#") begin
            op_q.push_back(op);
            f0_q.push_back(f0);
            f1_q.push_back(f1);
            f2_q.push_back(f2);
         end
         code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
      // bus cycles per case plus 12 frames at the divider in force
      cycles = 200;
      div_run = 16;
      foreach (op_q[i]) begin
         if (op_q[i] == "D") begin
            div_run = longint'(f0_q[i][15:0]);
         end
         cycles = cycles + CASE_BUS_CYCLES + 120 * div_run;
         if (op_q[i] == "C") begin
            cycles = cycles + longint'(f1_q[i]);
         end
      end
      watchdog_ns = 2 * cycles * CLK_PERIOD;
   endtask

   initial begin : watchdog
      wait (watchdog_armed);
      #(watchdog_ns);
      abort_run("watchdog expired, the run timed out");
   end

   initial begin : main
      sys_pkg::bus_data_t rd;
      clk       = 1'b0;
      rst_n     = 1'b0;
      valid     = 1'b0;
      address   = '0;
      wdata     = '0;
      wstrb     = '0;
      uart_rxd  = 1'b1;
      uart_cts  = 1'b1;
      lfsr      = 32'h486bb83a;
      div_model = 16;
      load_cases();
      watchdog_armed = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      compare_bit("ready", 1'b0, ready);
      compare_bit("uart_txd", 1'b1, uart_txd);
      compare_bit("uart_rts", 1'b1, uart_rts);
      bus_access(ADDR_STATUS, '0, '0, rd);
      compare_data("status", '0, rd);
      bus_access(ADDR_DIV, '0, '0, rd);
      compare_data("div", DIV_AFTER_RESET, rd);
      for (int i = 0; i < op_q.size(); i++) begin
         run_case(op_q[i], f0_q[i], f1_q[i], f2_q[i]);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

//--- system.sv
`timescale 1ns/1ps

module system (
   input  logic                clk,
   input  logic                rst_n,

   // native bus from the external master
   input  logic                valid,
   input  sys_pkg::bus_addr_t  address,
   input  sys_pkg::bus_data_t  wdata,
   input  sys_pkg::bus_strb_t  wstrb,
   output sys_pkg::bus_data_t  rdata,
   output logic                ready,

   // serial line
   output logic                uart_txd,
   input  logic                uart_rxd,
   output logic                uart_rts,
   input  logic                uart_cts
);

   iob_bus_if m_bus ();
   iob_bus_if s_bus [sys_pkg::N_SLAVES] ();

   logic                      tx_start;
   sys_pkg::uart_byte_t       tx_data;
   logic [sys_pkg::DIV_W-1:0] uart_div;
   logic                      tx_busy;
   sys_pkg::uart_byte_t       rx_data;
   logic                      rx_done;

   assign m_bus.valid   = valid;
   assign m_bus.address = address;
   assign m_bus.wdata   = wdata;
   assign m_bus.wstrb   = wstrb;
   assign rdata         = m_bus.rdata;
   assign ready         = m_bus.ready;

   split #(
      .N_SLAVES (sys_pkg::N_SLAVES)
   ) bus_split (
      .clk   (clk),
      .rst_n (rst_n),
      .m_bus (m_bus),
      .s_bus (s_bus)
   );

   int_mem int_mem0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (s_bus[sys_pkg::SEL_MEM])
   );

   iob_uart uart (
      .clk      (clk),
      .rst_n    (rst_n),
      .bus      (s_bus[sys_pkg::SEL_UART]),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_div   (uart_div),
      .tx_busy  (tx_busy),
      .rx_data  (rx_data),
      .rx_done  (rx_done),
      .rts      (uart_rts)
   );

   uart_tx uart_tx0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .tx_div   (uart_div),
      .cts      (uart_cts),
      .txd      (uart_txd),
      .tx_busy  (tx_busy)
   );

   // receiver shares the programmed bit period
   uart_rx uart_rx0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rxd     (uart_rxd),
      .rx_div  (uart_div),
      .rx_data (rx_data),
      .rx_done (rx_done)
   );

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      rxd,
   input  logic [sys_pkg::DIV_W-1:0] rx_div,
   output sys_pkg::uart_byte_t       rx_data,
   output logic                      rx_done
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                 state;
   logic [2:0]                rxd_sync;
   logic                      rx_bit;
   logic                      fall;
   logic [sys_pkg::DIV_W-1:0] div_q;
   logic [sys_pkg::DIV_W-1:0] cnt_q;
   logic [2:0]                bit_q;
   sys_pkg::uart_byte_t       shift_q;
   logic                      bit_end;

   // two flops against metastability, third one for the edge
   assign rx_bit  = rxd_sync[1];
   assign fall    = rxd_sync[2] & ~rxd_sync[1];
   assign bit_end = (cnt_q == div_q - sys_pkg::DIV_W'(1));

   always_ff @(posedge clk) begin
      if (state == RX_IDLE && fall) begin
         div_q <= rx_div;
      end
      // lsb arrives first, shift in from the top
      if (state == RX_DATA && bit_end) begin
         shift_q <= {rx_bit, shift_q[7:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= RX_IDLE;
         rxd_sync <= '1;
         cnt_q    <= '0;
         bit_q    <= '0;
         rx_done  <= 1'b0;
      end else begin
         rxd_sync <= {rxd_sync[1:0], rxd};
         rx_done  <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (fall) begin
                  cnt_q <= '0;
                  state <= RX_START;
               end
            end
            RX_START: begin
               // half a period in, the start bit must still be low
               if (cnt_q == (div_q >> 1)) begin
                  cnt_q <= '0;
                  bit_q <= '0;
                  state <= rx_bit ? RX_IDLE : RX_DATA;
               end else begin
                  cnt_q <= cnt_q + sys_pkg::DIV_W'(1);
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  cnt_q <= '0;
                  if (bit_q == 3'd7) begin
                     state <= RX_STOP;
                  end else begin
                     bit_q <= bit_q + 3'd1;
                  end
               end else begin
                  cnt_q <= cnt_q + sys_pkg::DIV_W'(1);
               end
            end
            default: begin
               // framing error just drops the byte
               if (bit_end) begin
                  cnt_q   <= '0;
                  rx_done <= rx_bit;
                  state   <= RX_IDLE;
               end else begin
                  cnt_q <= cnt_q + sys_pkg::DIV_W'(1);
               end
            end
         endcase
      end
   end

   assign rx_data = shift_q;

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      tx_start,
   input  sys_pkg::uart_byte_t       tx_data,
   input  logic [sys_pkg::DIV_W-1:0] tx_div,
   input  logic                      cts,
   output logic                      txd,
   output logic                      tx_busy
);

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_WAIT,
      TX_SEND
   } tx_state_t;

   tx_state_t                 state;
   logic [9:0]                shift_q;
   logic [sys_pkg::DIV_W-1:0] div_q;
   logic [sys_pkg::DIV_W-1:0] cnt_q;
   logic [3:0]                bit_q;
   sys_pkg::uart_byte_t       data_q;
   logic [1:0]                cts_sync;
   logic                      bit_end;

   assign bit_end = (cnt_q == div_q - sys_pkg::DIV_W'(1));

   // payload latched when a frame is accepted
   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_start) begin
         data_q <= tx_data;
         div_q  <= tx_div;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= TX_IDLE;
         shift_q  <= '1;
         cnt_q    <= '0;
         bit_q    <= '0;
         cts_sync <= '0;
      end else begin
         cts_sync <= {cts_sync[0], cts};
         case (state)
            TX_IDLE: begin
               if (tx_start) begin
                  state <= TX_WAIT;
               end
            end
            TX_WAIT: begin
               // frame only starts once the receiver allows it
               if (cts_sync[1]) begin
                  shift_q <= {1'b1, data_q, 1'b0};
                  cnt_q   <= '0;
                  bit_q   <= '0;
                  state   <= TX_SEND;
               end
            end
            default: begin
               if (bit_end) begin
                  cnt_q   <= '0;
                  // ones shift in so the line idles high
                  shift_q <= {1'b1, shift_q[9:1]};
                  if (bit_q == 4'd9) begin
                     state <= TX_IDLE;
                  end else begin
                     bit_q <= bit_q + 4'd1;
                  end
               end else begin
                  cnt_q <= cnt_q + sys_pkg::DIV_W'(1);
               end
            end
         endcase
      end
   end

   assign txd     = shift_q[0];
   assign tx_busy = (state != TX_IDLE);

endmodule

//--- iob_uart.sv
`timescale 1ns/1ps

module iob_uart (
   input  logic                     clk,
   input  logic                     rst_n,
   iob_bus_if.slave                 bus,

   // serializer side
   output logic                     tx_start,
   output sys_pkg::uart_byte_t      tx_data,
   output logic [sys_pkg::DIV_W-1:0] tx_div,
   input  logic                     tx_busy,

   // deserializer side
   input  sys_pkg::uart_byte_t      rx_data,
   input  logic                     rx_done,

   output logic                     rts
);

   logic [sys_pkg::UART_ADDR_W-1:0] reg_sel;
   logic                            access;
   logic                            wr;
   logic                            busy_flag;
   logic                            rx_valid;
   sys_pkg::uart_byte_t             rx_buf;
   logic [sys_pkg::DIV_W-1:0]       div_q;
   sys_pkg::bus_data_t              status_w;

   assign reg_sel = bus.address[sys_pkg::UART_ADDR_W+1:2];
   assign access  = bus.valid & ~bus.ready;
   assign wr      = |bus.wstrb;

   // a start already issued counts as busy until the serializer catches up
   assign busy_flag = tx_busy | tx_start;

   always_comb begin
      status_w = '0;
      status_w[sys_pkg::STAT_TX_BUSY]  = busy_flag;
      status_w[sys_pkg::STAT_RX_VALID] = rx_valid;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ready <= 1'b0;
         tx_start  <= 1'b0;
         rx_valid  <= 1'b0;
         div_q     <= sys_pkg::DIV_RESET;
      end else begin
         bus.ready <= access;
         tx_start  <= 1'b0;

         // txdata write is dropped while a frame is pending
         if (access && wr && reg_sel == sys_pkg::UART_TXDATA && !busy_flag) begin
            tx_start <= 1'b1;
         end

         if (access && wr && reg_sel == sys_pkg::UART_DIV) begin
            div_q <= bus.wdata[sys_pkg::DIV_W-1:0];
         end

         // a new byte wins over a read in the same cycle
         if (rx_done) begin
            rx_valid <= 1'b1;
         end else if (access && !wr && reg_sel == sys_pkg::UART_RXDATA) begin
            rx_valid <= 1'b0;
         end
      end
   end

   // payload registers
   always_ff @(posedge clk) begin
      if (access && wr && reg_sel == sys_pkg::UART_TXDATA && !busy_flag) begin
         tx_data <= bus.wdata[7:0];
      end
      if (rx_done) begin
         rx_buf <= rx_data;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            sys_pkg::UART_TXDATA: bus.rdata <= sys_pkg::bus_data_t'(tx_data);
            sys_pkg::UART_RXDATA: bus.rdata <= sys_pkg::bus_data_t'(rx_buf);
            sys_pkg::UART_STATUS: bus.rdata <= status_w;
            default:              bus.rdata <= sys_pkg::bus_data_t'(div_q);
         endcase
      end
   end

   assign tx_div = div_q;
   // hold off the far end while a byte waits
   assign rts    = ~rx_valid;

endmodule

//--- int_mem.sv
`timescale 1ns/1ps

module int_mem (
   input logic      clk,
   input logic      rst_n,
   iob_bus_if.slave bus
);

   localparam int DEPTH = 2 ** sys_pkg::MEM_ADDR_W;

   sys_pkg::bus_data_t              mem [DEPTH];
   logic [sys_pkg::MEM_ADDR_W-1:0]  idx;
   sys_pkg::bus_data_t              merged;
   logic                            access;
   logic                            wr;

   // word index, upper address bits alias
   assign idx    = bus.address[sys_pkg::MEM_ADDR_W+1:2];
   // valid stays up during the ready cycle, take it only once
   assign access = bus.valid & ~bus.ready;
   assign wr     = |bus.wstrb;

   // old word with the strobed bytes replaced
   always_comb begin
      merged = mem[idx];
      for (int b = 0; b < sys_pkg::STRB_W; b++) begin
         if (bus.wstrb[b]) begin
            merged[8*b +: 8] = bus.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && wr) begin
         mem[idx] <= merged;
      end
      if (access) begin
         bus.rdata <= merged;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ready <= 1'b0;
      end else begin
         bus.ready <= access;
      end
   end

endmodule

//--- split.sv
`timescale 1ns/1ps

module split #(
   parameter int N_SLAVES = sys_pkg::N_SLAVES
) (
   input logic       clk,
   input logic       rst_n,
   iob_bus_if.slave  m_bus,
   iob_bus_if.master s_bus [N_SLAVES]
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0]   sel_d;
   logic [SEL_W-1:0]   sel_q;
   logic               busy;
   sys_pkg::bus_data_t s_rdata [N_SLAVES];
   logic               s_ready [N_SLAVES];

   // slave index lives in the top address bits
   assign sel_d = m_bus.address[sys_pkg::ADDR_W-1 -: SEL_W];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy  <= 1'b0;
         sel_q <= '0;
      end else if (busy) begin
         // transaction closes on the returned ready
         if (m_bus.ready) begin
            busy <= 1'b0;
         end
      end else if (m_bus.valid) begin
         busy  <= 1'b1;
         sel_q <= sel_d;
      end
   end

   genvar i;
   generate
      for (i = 0; i < N_SLAVES; i++) begin : g_slave
         // request fields are shared, valid only goes to the latched slave
         assign s_bus[i].valid   = m_bus.valid & busy & (sel_q == SEL_W'(i));
         assign s_bus[i].address = m_bus.address;
         assign s_bus[i].wdata   = m_bus.wdata;
         assign s_bus[i].wstrb   = m_bus.wstrb;

         assign s_rdata[i] = s_bus[i].rdata;
         assign s_ready[i] = s_bus[i].ready;
      end
   endgenerate

   // response from the slave that owns the transaction
   assign m_bus.rdata = s_rdata[sel_q];
   assign m_bus.ready = busy & s_ready[sel_q];

endmodule

//--- iob_bus_if.sv
`timescale 1ns/1ps

interface iob_bus_if;

   // request side
   logic                valid;
   sys_pkg::bus_addr_t  address;
   sys_pkg::bus_data_t  wdata;
   sys_pkg::bus_strb_t  wstrb;

   // response side, ready is a single-cycle pulse
   sys_pkg::bus_data_t  rdata;
   logic                ready;

   modport master (
      output valid,
      output address,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport slave (
      input  valid,
      input  address,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

//--- sys_pkg.sv
package sys_pkg;

   // native bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 16;
   localparam int STRB_W = DATA_W / 8;

   // address map, slave picked by the top address bit
   localparam int N_SLAVES = 2;
   localparam int SEL_MEM  = 0;
   localparam int SEL_UART = 1;

   // word index taken from address bits 11..2
   localparam int MEM_ADDR_W = 10;

   // uart register select from address bits 3..2
   localparam int UART_ADDR_W = 2;

   localparam logic [UART_ADDR_W-1:0] UART_TXDATA = UART_ADDR_W'(0);
   localparam logic [UART_ADDR_W-1:0] UART_RXDATA = UART_ADDR_W'(1);
   localparam logic [UART_ADDR_W-1:0] UART_STATUS = UART_ADDR_W'(2);
   localparam logic [UART_ADDR_W-1:0] UART_DIV    = UART_ADDR_W'(3);

   // status word bits
   localparam int STAT_TX_BUSY  = 0;
   localparam int STAT_RX_VALID = 1;

   // bit period in clocks
   localparam int DIV_W = 16;
   localparam logic [DIV_W-1:0] DIV_RESET = DIV_W'(16);

   typedef logic [DATA_W-1:0] bus_data_t;
   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [STRB_W-1:0] bus_strb_t;
   typedef logic [7:0]        uart_byte_t;

endpackage
